// File: colmix.f
hw/colmix_pkg.sv
hw/video_timing.sv
hw/palette_ram.sv
hw/pixel_mixer.sv
hw/colmix_top.sv
tb/colmix_checker.sv
tb/colmix_tb.sv

// File: tb/colmix_tb.sv
`timescale 1ns/1ps

module colmix_tb;
    import colmix_pkg::*;

    localparam int CEN_TIMEOUT   = 16;      // clocks, enable every 4
    localparam int LINE_TIMEOUT  = 2000;    // one line is 1536 clocks
    localparam int FRAME_TIMEOUT = 500000;  // one frame is about 405k clocks
    localparam int ROWS_PER_LINE = 64;      // 2 pixels per row, stays inside 256 active

    logic       clk;
    logic       rst;
    layer_pxl_t pixels;
    prog_req_t  prog;
    rgb_t       rgb;
    logic       lhbl;
    logic       lvbl;
    logic       pxl_cen;

    logic [31:0] lfsr_state;
    logic [3:0]  pal_red   [0:255];  // testbench copy of the PROMs
    logic [3:0]  pal_green [0:255];
    logic [3:0]  pal_blue  [0:255];
    string       row_name [$];       // stimulus table
    layer_pxl_t  row_pxl  [$];

    colmix_top colmix_top_i (
        .clk     (clk),
        .rst     (rst),
        .pixels  (pixels),
        .prog    (prog),
        .rgb     (rgb),
        .lhbl    (lhbl),
        .lvbl    (lvbl),
        .pxl_cen (pxl_cen)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;  // 4 ns period

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic rand_bits(input int n, output logic [7:0] val);
        val = '0;
        for (int b = 0; b < n; b++) begin
            val        = {val[6:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // char over obj over scroll, bank in the top two bits
    function automatic logic [7:0] expected_addr(input layer_pxl_t p);
        if (p.char_code != TRANSP_CODE)
            return {4'b1100, p.char_code};
        else if (p.obj_code != TRANSP_CODE)
            return {4'b1000, p.obj_code};
        else
            return {2'b00, p.scr_code};
    endfunction

    function automatic rgb_t palette_rgb(input logic [7:0] a);
        return '{red: pal_red[a], green: pal_green[a], blue: pal_blue[a]};
    endfunction

    function automatic rgb_t expected_rgb(input layer_pxl_t p);
        return palette_rgb(expected_addr(p));
    endfunction

    task automatic stop_on_error();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
            stop_on_error();
        end
    endtask

    // all testbench activity sits 1 ns after a rising edge
    task automatic step_clk();
        @(posedge clk);
        #1;
    endtask

    // returns 1 ns after the next clk edge that has pxl_cen high
    task automatic wait_cen();
        int n;
        n = 0;
        while (pxl_cen !== 1'b1) begin
            step_clk();
            n++;
            if (n > CEN_TIMEOUT) begin
                $display("timeout waiting for pxl_cen");
                stop_on_error();
            end
        end
        step_clk();  // this edge is the enabled one
    endtask

    // wait for lhbl (or lvbl) to read low
    task automatic wait_blank(input bit vertical, input int limit);
        int n;
        n = 0;
        while ((vertical ? lvbl : lhbl) !== 1'b0) begin
            step_clk();
            n++;
            if (n > limit) begin
                $display("timeout waiting for %s blanking", vertical ? "vertical" : "horizontal");
                stop_on_error();
            end
        end
    endtask

    // first clk of a visible line, lhbl just rose with lvbl high
    task automatic wait_line_start();
        int n;
        bit seen_low;
        n        = 0;
        seen_low = 1'b0;
        while (!(seen_low && lhbl === 1'b1 && lvbl === 1'b1)) begin
            if (lhbl === 1'b0)
                seen_low = 1'b1;
            step_clk();
            n++;
            if (n > FRAME_TIMEOUT) begin
                $display("timeout waiting for the start of a visible line");
                stop_on_error();
            end
        end
    endtask

    task automatic add_row(input string name, input logic [3:0] c, input logic [3:0] o,
                           input logic [5:0] s);
        row_name.push_back(name);
        row_pxl.push_back('{char_code: c, obj_code: o, scr_code: s});
    endtask

    // random contents into all three PROMs through the load port
    task automatic program_palettes();
        logic [7:0] v;
        for (int s = 1; s <= 3; s++) begin
            for (int a = 0; a < 256; a++) begin
                rand_bits(4, v);
                case (s)
                    1:       pal_red[a]   = v[3:0];
                    2:       pal_green[a] = v[3:0];
                    default: pal_blue[a]  = v[3:0];
                endcase
                prog.sel  = prom_sel_e'(s);
                prog.addr = 8'(a);
                prog.din  = v[3:0];
                wait_cen();            // write lands on this enable
                prog.sel  = PROM_NONE;
            end
        end
    endtask

    task automatic build_rows();
        logic [7:0] o;
        logic [7:0] s;
        for (int i = 0; i < 64; i++)
            add_row("scroll_readback", 4'hf, 4'hf, 6'(i));  // entries 0..63
        for (int i = 0; i < 15; i++) begin
            rand_bits(4, o);
            rand_bits(6, s);
            add_row("char_readback", 4'(i), o[3:0], s[5:0]);  // entries 192..206
        end
        for (int i = 0; i < 15; i++) begin
            rand_bits(6, s);
            add_row("obj_readback", 4'hf, 4'(i), s[5:0]);  // entries 128..142
        end
        add_row("char_over_obj", 4'h2, 4'h9, 6'd17);
        add_row("char_over_scroll", 4'h0, 4'hf, 6'd63);
        add_row("obj_over_scroll", 4'hf, 4'h0, 6'd42);
        add_row("obj_over_scroll", 4'hf, 4'he, 6'd1);
        add_row("scroll_fallback", 4'hf, 4'hf, 6'd33);
    endtask

    // each row: old colour after one enable, new colour after two
    task automatic run_rows();
        layer_pxl_t prev;
        int on_line;
        prev    = pixels;
        on_line = 0;
        wait_line_start();
        for (int i = 0; i < row_pxl.size(); i++) begin
            if (on_line == ROWS_PER_LINE) begin
                wait_line_start();  // pixels held, mix register keeps prev
                on_line = 0;
            end
            pixels = row_pxl[i];
            wait_cen();
            check_val({row_name[i], "_latency"}, expected_rgb(prev), rgb);
            wait_cen();
            check_val(row_name[i], expected_rgb(row_pxl[i]), rgb);
            prev = row_pxl[i];
            on_line++;
        end
    endtask

    // border colour is entry 0 whatever the layers say
    task automatic check_blanking();
        rgb_t border;
        border = palette_rgb(8'd0);
        pixels = '{char_code: 4'h1, obj_code: 4'h3, scr_code: 6'd9};
        wait_blank(1'b0, LINE_TIMEOUT);
        check_val("hblank_border", border, rgb);
        for (int i = 0; i < 16; i++) begin
            wait_cen();
            check_val("hblank_border", border, rgb);
        end
        wait_blank(1'b1, FRAME_TIMEOUT);
        check_val("vblank_border", border, rgb);
        for (int i = 0; i < 400; i++) begin  // spans an active h window too
            wait_cen();
            check_val("vblank_border", border, rgb);
            check_val("vblank_level", 32'd0, lvbl);
        end
    endtask

    initial begin
        rst        = 1'b1;
        pixels     = '{char_code: 4'hf, obj_code: 4'hf, scr_code: 6'd0};
        prog       = '{sel: PROM_NONE, addr: '0, din: '0};
        lfsr_state = 32'ha199b26f;

        repeat (5) @(posedge clk);
        #1 rst = 1'b0;

        // nothing running yet
        check_val("reset_pxl_cen", 32'd0, pxl_cen);
        check_val("reset_lhbl", 32'd0, lhbl);
        check_val("reset_lvbl", 32'd0, lvbl);

        program_palettes();
        build_rows();
        run_rows();
        check_blanking();

        if (colmix_top_i.u_mixer.u_checker.err_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("assertion checker flagged %0d failures",
                     colmix_top_i.u_mixer.u_checker.err_count);
            stop_on_error();
        end
    end

endmodule

// File: tb/colmix_checker.sv
`timescale 1ns/1ps

module colmix_checker (
    input logic                  clk,
    input logic                  rst,
    input logic                  cen6,
    input colmix_pkg::rgb_t      rgb,
    input colmix_pkg::prog_req_t prog,
    input logic                  we_red,
    input logic                  we_green,
    input logic                  we_blue
);
    import colmix_pkg::*;

    int unsigned err_count = 0;  // read by the testbench at the end

    // pixel enable is a single clk pulse
    cen_single: assert property (@(posedge clk) disable iff (rst) cen6 |=> !cen6)
        else begin
            $error("cen6 held high for two clocks");
            err_count++;
        end

    // and it comes back within one pixel period
    cen_period: assert property (@(posedge clk) disable iff (rst)
        cen6 |-> ##[1:CEN_DIV] cen6)
        else begin
            $error("cen6 did not recur within CEN_DIV clocks");
            err_count++;
        end

    // colour only moves on the clk after an enable
    rgb_on_cen: assert property (@(posedge clk) disable iff (rst)
        $changed(rgb) |-> $past(cen6))
        else begin
            $error("rgb changed away from a pixel enable");
            err_count++;
        end

    // idle load port never writes a PROM
    no_idle_write: assert property (@(posedge clk) disable iff (rst)
        (prog.sel == PROM_NONE) |-> !(we_red || we_green || we_blue))
        else begin
            $error("palette write enable high with load port idle");
            err_count++;
        end

endmodule

bind pixel_mixer colmix_checker u_checker (
    .clk      (clk),
    .rst      (rst),
    .cen6     (cen6),
    .rgb      (rgb),
    .prog     (prog),
    .we_red   (we_red),
    .we_green (we_green),
    .we_blue  (we_blue)
);

// File: hw/colmix_top.sv
`timescale 1ns/1ps

module colmix_top (
    input  logic                   clk,      // 24 MHz
    input  logic                   rst,
    input  colmix_pkg::layer_pxl_t pixels,   // sampled on pxl_cen
    input  colmix_pkg::prog_req_t  prog,     // palette load port
    output colmix_pkg::rgb_t       rgb,
    output logic                   lhbl,     // horizontal blank, active low
    output logic                   lvbl,     // vertical blank, active low
    output logic                   pxl_cen   // pixel enable for the generators
);

    logic cen6;
    logic hblank_n;  // raw timing blanks, one pixel ahead of rgb
    logic vblank_n;

    // raster timing and pixel enable
    video_timing u_timing (
        .clk      (clk),
        .rst      (rst),
        .cen6     (cen6),
        .hblank_n (hblank_n),
        .vblank_n (vblank_n)
    );

    // priority mux and palette PROMs
    pixel_mixer u_mixer (
        .clk      (clk),
        .rst      (rst),
        .cen6     (cen6),
        .pixels   (pixels),
        .prog     (prog),
        .hblank_n (hblank_n),
        .vblank_n (vblank_n),
        .rgb      (rgb),
        .lhbl     (lhbl),
        .lvbl     (lvbl)
    );

    // generators upstream run off the same enable
    assign pxl_cen = cen6;

endmodule

// File: hw/pixel_mixer.sv
`timescale 1ns/1ps

module pixel_mixer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen6,      // pixel enable
    input  colmix_pkg::layer_pxl_t pixels,    // layer codes for this pixel
    input  colmix_pkg::prog_req_t  prog,      // palette load port
    input  logic                   hblank_n,  // timing blanks, active low
    input  logic                   vblank_n,
    output colmix_pkg::rgb_t       rgb,
    output logic                   lhbl,      // blanks aligned with rgb
    output logic                   lvbl
);
    import colmix_pkg::*;

    logic [PAL_AW-1:0] mix_addr;  // winning palette address, one pixel late
    logic [PAL_AW-1:0] pal_addr;  // address into all three PROMs
    logic              char_opaque;
    logic              obj_opaque;
    logic              we_red;
    logic              we_green;
    logic              we_blue;
    logic [PAL_DW-1:0] red_q;
    logic [PAL_DW-1:0] green_q;
    logic [PAL_DW-1:0] blue_q;

    assign char_opaque = (pixels.char_code != TRANSP_CODE);
    assign obj_opaque  = (pixels.obj_code  != TRANSP_CODE);

    // fixed priority, char over obj over scroll
    // top two address bits select the palette bank
    always_ff @(posedge clk) begin
        if (rst) begin
            mix_addr <= '0;
        end else if (cen6) begin
            if (char_opaque)
                mix_addr <= {2'b11, 2'b00, pixels.char_code};  // char bank
            else if (obj_opaque)
                mix_addr <= {2'b10, 2'b00, pixels.obj_code};   // object bank
            else
                mix_addr <= {2'b00, pixels.scr_code};          // scroll bank
        end
    end

    // programming wins, then blanking forces entry 0
    always_comb begin
        if (prog.sel != PROM_NONE)
            pal_addr = prog.addr;
        else if (hblank_n && vblank_n)
            pal_addr = mix_addr;
        else
            pal_addr = '0;  // border colour
    end

    // one write enable per PROM
    assign we_red   = (prog.sel == PROM_RED);
    assign we_green = (prog.sel == PROM_GREEN);
    assign we_blue  = (prog.sel == PROM_BLUE);

    palette_ram #(
        .aw (PAL_AW),
        .dw (PAL_DW)
    ) u_red (
        .clk  (clk),
        .cen  (cen6),
        .addr (pal_addr),
        .din  (prog.din),
        .we   (we_red),
        .q    (red_q)
    );

    palette_ram #(
        .aw (PAL_AW),
        .dw (PAL_DW)
    ) u_green (
        .clk  (clk),
        .cen  (cen6),
        .addr (pal_addr),
        .din  (prog.din),
        .we   (we_green),
        .q    (green_q)
    );

    palette_ram #(
        .aw (PAL_AW),
        .dw (PAL_DW)
    ) u_blue (
        .clk  (clk),
        .cen  (cen6),
        .addr (pal_addr),
        .din  (prog.din),
        .we   (we_blue),
        .q    (blue_q)
    );

    assign rgb = '{red: red_q, green: green_q, blue: blue_q};

    // PROM read adds a pixel of delay, blanks follow it
    always_ff @(posedge clk) begin
        if (rst) begin
            lhbl <= 1'b0;
            lvbl <= 1'b0;
        end else if (cen6) begin
            lhbl <= hblank_n;
            lvbl <= vblank_n;
        end
    end

endmodule

// File: hw/palette_ram.sv
`timescale 1ns/1ps

module palette_ram #(
    parameter int aw = colmix_pkg::PAL_AW,  // address bits
    parameter int dw = colmix_pkg::PAL_DW   // data bits
) (
    input  logic          clk,
    input  logic          cen,   // pixel rate enable
    input  logic [aw-1:0] addr,
    input  logic [dw-1:0] din,
    input  logic          we,
    output logic [dw-1:0] q      // registered read data
);

    // PROM image, cleared so simulation starts from black
    logic [dw-1:0] mem [0:(2**aw)-1] = '{default: '0};

    // single port, read and write share addr
    // q returns the old word on a write, read before write
    always_ff @(posedge clk) begin
        if (cen) begin
            q <= mem[addr];
            if (we)
                mem[addr] <= din;  // load port write
        end
    end

endmodule

// File: hw/video_timing.sv
`timescale 1ns/1ps

module video_timing (
    input  logic clk,       // 24 MHz
    input  logic rst,
    output logic cen6,      // 6 MHz pixel enable, one clk wide
    output logic hblank_n,  // high during visible pixels
    output logic vblank_n   // high during visible lines
);
    import colmix_pkg::*;

    logic [1:0]        div;   // clk divider for the pixel enable
    logic [HCNT_W-1:0] hcnt;  // pixel within line
    logic [VCNT_W-1:0] vcnt;  // line within frame
    logic              h_wrap;
    logic              v_wrap;

    // divide by CEN_DIV, cen6 registered so it is clean out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            div  <= '0;
            cen6 <= 1'b0;
        end else begin
            div  <= div + 2'd1;
            // fires on the 4th clk after reset drops
            cen6 <= (div == 2'(CEN_DIV - 2));
        end
    end

    assign h_wrap = (hcnt == HCNT_W'(H_TOTAL - 1));  // last pixel of line
    assign v_wrap = (vcnt == VCNT_W'(V_TOTAL - 1));  // last line of frame

    // horizontal counter, one step per pixel
    always_ff @(posedge clk) begin
        if (rst) begin
            hcnt <= '0;
        end else if (cen6) begin
            if (h_wrap)
                hcnt <= '0;
            else
                hcnt <= hcnt + 1'b1;
        end
    end

    // vertical counter, one step per line
    always_ff @(posedge clk) begin
        if (rst) begin
            vcnt <= '0;
        end else if (cen6 && h_wrap) begin
            if (v_wrap)
                vcnt <= '0;
            else
                vcnt <= vcnt + 1'b1;
        end
    end

    // blanking flags, only move on pixel boundaries
    // they describe the pixel the counters point at on this enable
    always_ff @(posedge clk) begin
        if (rst) begin
            hblank_n <= 1'b0;  // blanked until timing runs
            vblank_n <= 1'b0;
        end else if (cen6) begin
            hblank_n <= (hcnt < HCNT_W'(H_ACTIVE));
            vblank_n <= (vcnt < VCNT_W'(V_ACTIVE));
        end
    end

endmodule

// File: hw/colmix_pkg.sv
package colmix_pkg;

    // raster geometry, in 6 MHz pixels and lines
    localparam int CEN_DIV  = 4;    // 24 MHz clocks per pixel
    localparam int H_TOTAL  = 384;  // pixels per line incl. blanking
    localparam int H_ACTIVE = 256;  // visible pixels
    localparam int V_TOTAL  = 264;  // lines per frame
    localparam int V_ACTIVE = 224;  // visible lines

    // counter widths, wide enough for the totals above
    localparam int HCNT_W = $clog2(H_TOTAL);
    localparam int VCNT_W = $clog2(V_TOTAL);

    // palette PROM geometry
    localparam int PAL_AW = 8;  // 256 entries
    localparam int PAL_DW = 4;  // one colour gun per PROM

    // all ones on a 4-bit layer code means no pixel there
    localparam logic [3:0] TRANSP_CODE = 4'hf;

    // which palette PROM a programming write targets
    typedef enum logic [1:0] {
        PROM_NONE  = 2'd0,  // idle, normal video
        PROM_RED   = 2'd1,
        PROM_GREEN = 2'd2,
        PROM_BLUE  = 2'd3
    } prom_sel_e;

    // palette load request, stands in for the PROM images
    typedef struct packed {
        prom_sel_e          sel;   // target PROM
        logic [PAL_AW-1:0]  addr;  // entry to write
        logic [PAL_DW-1:0]  din;   // colour value
    } prog_req_t;

    // layer codes coming from the tile and sprite generators
    typedef struct packed {
        logic [3:0] char_code;  // text layer, top priority
        logic [3:0] obj_code;   // sprites
        logic [5:0] scr_code;   // scroll background, always opaque
    } layer_pxl_t;

    // final colour out of the palette PROMs
    typedef struct packed {
        logic [PAL_DW-1:0] red;
        logic [PAL_DW-1:0] green;
        logic [PAL_DW-1:0] blue;
    } rgb_t;

endpackage
